//--- logic/boothParamPkg.sv
package boothParamPkg;

    // operand size for both multiplicand and multiplier
    localparam int opWidth = 16;

    // full signed product, accumulator on top of Q
    localparam int prodWidth = 2 * opWidth;

    // radix-2 Booth retires one multiplier bit per step
    localparam int stepCount = opWidth;

    // must reach stepCount itself, not only stepCount-1
    localparam int countWidth = $clog2(stepCount + 1);

endpackage : boothParamPkg

//--- logic/boothTypesPkg.sv
package boothTypesPkg;
    import boothParamPkg::*;

    // one multiply request as seen at the top level
    typedef struct packed {
        logic signed [opWidth-1:0] multiplicand; // goes to M
        logic signed [opWidth-1:0] multiplier;   // goes to Q
    } boothOperandsT;

    // what the accumulator does before the shift
    typedef enum logic [1:0] {
        actPass = 2'b00, // bit pair 00 or 11
        actAdd  = 2'b01, // bit pair 01, end of a run of ones
        actSub  = 2'b10  // bit pair 10, start of a run of ones
    } boothActionT;

    // controller to datapath
    typedef struct packed {
        logic        load;   // capture operands, clear acc and qPrev
        logic        step;   // one add/sub/pass then shift
        boothActionT action;
    } boothCtrlT;

    // datapath to controller, the Booth bit pair
    typedef struct packed {
        logic qLsb;  // Q[0]
        logic qPrev; // Q[-1]
    } boothPairT;

endpackage : boothTypesPkg

//--- logic/boothDatapath.sv
`timescale 1ns/1ps

module boothDatapath (
    input  logic                                     clk,
    input  logic                                     reset,
    input  boothTypesPkg::boothOperandsT             operands,
    input  boothTypesPkg::boothCtrlT                 ctrl,
    output boothTypesPkg::boothPairT                 pair,
    output logic signed [boothParamPkg::prodWidth-1:0] product
);
    import boothParamPkg::*;
    import boothTypesPkg::*;

    logic signed [opWidth-1:0]   mReg;      // multiplicand M
    logic signed [opWidth-1:0]   acc;       // accumulator, upper product half
    logic        [opWidth-1:0]   qReg;      // multiplier, shifts out toward qPrev
    logic                        qPrev;     // the Q-minus-one bit

    logic signed [opWidth:0]     addOut;    // acc after add/sub/pass, one guard bit
    logic        [prodWidth-1:0] shifted;   // {addOut, qReg} after the shift

    // multiplicand register
    // only a load changes it, it holds during the steps
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mReg <= '0;
        end else if (ctrl.load) begin
            mReg <= operands.multiplicand;
        end
    end

    // accumulator
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            acc <= '0;
        end else if (ctrl.load) begin
            acc <= '0; // each multiply starts from zero
        end else if (ctrl.step) begin
            acc <= shifted[prodWidth-1:opWidth];
        end
    end

    // Q register, multiplier bits leave through bit 0
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            qReg <= '0;
        end else if (ctrl.load) begin
            qReg <= operands.multiplier;
        end else if (ctrl.step) begin
            qReg <= shifted[opWidth-1:0];
        end
    end

    // Q-minus-one, catches the bit that falls off Q
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            qPrev <= 1'b0;
        end else if (ctrl.load) begin
            qPrev <= 1'b0; // implied zero right of the multiplier lsb
        end else if (ctrl.step) begin
            qPrev <= qReg[0];
        end
    end

    // add/subtract/pass selection
    // sign-extended by one bit, acc - M overflows 16 bits when M is -32768
    always_comb begin
        case (ctrl.action)
            actAdd:  addOut = {acc[opWidth-1], acc} + {mReg[opWidth-1], mReg};
            actSub:  addOut = {acc[opWidth-1], acc} - {mReg[opWidth-1], mReg};
            default: addOut = {acc[opWidth-1], acc}; // pass, pair 00 or 11
        endcase
    end

    // arithmetic shift right of the acc:Q pair
    // guard bit of the sum becomes the sign of the new acc
    always_comb begin
        shifted = {addOut, qReg[opWidth-1:1]};
    end

    // bit pair the controller decodes for the next step
    always_comb begin
        pair.qLsb  = qReg[0];
        pair.qPrev = qPrev;
    end

    // registered result, stable between steps and after done
    assign product = {acc, qReg};

endmodule : boothDatapath

//--- logic/boothController.sv
`timescale 1ns/1ps

module boothController (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  boothTypesPkg::boothPairT pair,
    output boothTypesPkg::boothCtrlT ctrl,
    output logic                     busy,
    output logic                     done
);
    import boothParamPkg::*;
    import boothTypesPkg::*;

    typedef enum logic [1:0] {
        stIdle, // waiting for start
        stRun,  // shifting, one Booth step per cycle
        stDone  // result valid, one cycle only
    } stateT;

    stateT                 state;
    stateT                 stateNext;
    logic [countWidth-1:0] count;     // steps already taken
    logic [countWidth-1:0] countNext;
    logic                  accept;    // start seen while not running
    boothActionT           action;

    // start is ignored while running, no error flag
    // done cycle accepts too, so multiplies can run back to back
    assign accept = start && (state == stIdle || state == stDone);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= stIdle;
            count <= '0;
        end else begin
            state <= stateNext;
            count <= countNext;
        end
    end

    // next state and step counter
    always_comb begin
        stateNext = state;
        countNext = count;
        case (state)
            stIdle: begin
                if (accept) begin
                    stateNext = stRun;
                    countNext = '0;
                end
            end
            stRun: begin
                countNext = count + 1'b1;
                if (countNext == countWidth'(stepCount)) begin // last step this edge
                    stateNext = stDone;
                    countNext = '0;
                end
            end
            stDone: begin
                if (accept) begin
                    stateNext = stRun; // new operands loaded at this edge
                    countNext = '0;
                end else begin
                    stateNext = stIdle;
                end
            end
            default: begin
                stateNext = stIdle;
                countNext = '0;
            end
        endcase
    end

    // Booth recoding of {Q[0], Q[-1]}
    always_comb begin
        case ({pair.qLsb, pair.qPrev})
            2'b01:   action = actAdd;  // leaving a run of ones
            2'b10:   action = actSub;  // entering a run of ones
            default: action = actPass; // inside a run or between runs
        endcase
    end

    always_comb begin
        ctrl.load   = accept;
        ctrl.step   = (state == stRun);
        ctrl.action = action; // only used while step is high
    end

    assign busy = (state == stRun);
    assign done = (state == stDone); // one cycle, the state never holds

endmodule : boothController

//--- logic/boothMultiplier.sv
`timescale 1ns/1ps

module boothMultiplier (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       start,
    input  boothTypesPkg::boothOperandsT               operands,
    output logic signed [boothParamPkg::prodWidth-1:0] product,
    output logic                                       busy,
    output logic                                       done
);
    import boothTypesPkg::*;

    boothCtrlT ctrl; // load/step/action toward the datapath
    boothPairT pair; // Q[0] and Q[-1] back to the controller

    // sequencing and Booth decode
    boothController i_boothController (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .pair  (pair),
        .ctrl  (ctrl),
        .busy  (busy),
        .done  (done)
    );

    // M, accumulator and Q shift pair
    boothDatapath i_boothDatapath (
        .clk      (clk),
        .reset    (reset),
        .operands (operands),
        .ctrl     (ctrl),
        .pair     (pair),
        .product  (product) // straight out, already registered
    );

endmodule : boothMultiplier

//--- include/boothRef.svh
`ifndef BOOTH_REF_SVH
`define BOOTH_REF_SVH

// expected product for the checker
// plain signed multiply, done wide so no bit is lost on -32768 * -32768
function automatic logic signed [boothParamPkg::prodWidth-1:0] boothRefProduct(
    input logic signed [boothParamPkg::opWidth-1:0] multiplicand,
    input logic signed [boothParamPkg::opWidth-1:0] multiplier
);
    longint wideM;   // sign-extended multiplicand
    longint wideQ;   // sign-extended multiplier
    longint wideP;   // full product before trimming

    wideM = longint'(multiplicand);
    wideQ = longint'(multiplier);
    wideP = wideM * wideQ;

    // 16x16 signed always fits in 32 bits
    return wideP[boothParamPkg::prodWidth-1:0];
endfunction

`endif

//--- verif/boothMultiplierTb.sv
`timescale 1ns/1ps

module boothMultiplierTb;
    import boothParamPkg::*;
    import boothTypesPkg::*;

    `include "boothRef.svh"

    // 6 corners + 250 random + busy test, at most ~20 cycles each, plus reset and margin
    localparam int randomOps     = 250;
    localparam int timeoutCycles = 8000;

    logic                        clk;
    logic                        reset;
    logic                        start;
    boothOperandsT               operands;
    logic signed [prodWidth-1:0] product;
    logic                        busy;
    logic                        done;

    boothOperandsT pending[$];  // accepted requests, oldest first
    integer        seed;
    int            errors;
    int            checks;
    int            issued;      // starts the DUT accepted
    int            doneCount;
    int            cycles;      // timeout counter
    int            phase;       // cycles since the accepting edge
    bit            tracking;    // a multiply is in flight

    boothMultiplier i_boothMultiplier (
        .clk      (clk),
        .reset    (reset),
        .start    (start),
        .operands (operands),
        .product  (product),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    function automatic boothOperandsT makeOps(
        input logic signed [opWidth-1:0] multiplicand,
        input logic signed [opWidth-1:0] multiplier
    );
        boothOperandsT ops;
        ops.multiplicand = multiplicand;
        ops.multiplier   = multiplier;
        return ops;
    endfunction

    // raise start and hold it until the DUT can take it
    // returns at the negedge just before the accepting edge
    task automatic startOp(input boothOperandsT ops);
        @(posedge clk);
        start    <= 1'b1;
        operands <= ops;
        forever begin
            @(negedge clk);
            if (!busy) break; // idle or done cycle, next edge accepts
        end
        pending.push_back(ops);
        issued++;
    endtask

    task automatic dropStart();
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic waitDone();
        forever begin
            @(negedge clk);
            if (done) break;
        end
    endtask

    task automatic checkQuiet(input string when);
        if (busy) begin
            errors++;
            $display("busy is high %s", when);
        end
        if (done) begin
            errors++;
            $display("done is high %s", when);
        end
    endtask

    // product check, one per done pulse
    always @(negedge clk) begin : compareProducts
        boothOperandsT               head;
        logic signed [prodWidth-1:0] expected;
        if (reset && done) begin
            doneCount++;
            if (pending.size() == 0) begin
                errors++;
                $display("done pulse at %0t with no multiply pending", $time);
            end else begin
                head     = pending.pop_front();
                expected = boothRefProduct(head.multiplicand, head.multiplier);
                checks++;
                if (product !== expected) begin
                    errors++;
                    $display("FAIL time=%0t signal=product expected=%0d actual=%0d",
                             $time, expected, product);
                end
            end
        end
    end

    // latency and pulse shape, sampled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            if (tracking) begin
                phase = phase + 1;
                if (phase <= stepCount) begin // step cycles
                    if (!busy) begin
                        errors++;
                        $display("busy low in step cycle %0d at %0t", phase, $time);
                    end
                    if (done) begin
                        errors++;
                        $display("done came early, in step cycle %0d at %0t", phase, $time);
                    end
                end else begin
                    checks++;
                    if (!done) begin
                        errors++;
                        $display("done missing 16 cycles after start at %0t", $time);
                    end
                    if (busy) begin
                        errors++;
                        $display("busy still high in the done cycle at %0t", $time);
                    end
                    tracking = 1'b0;
                end
            end else if (done) begin
                errors++; // stretched pulse or spurious done
                $display("done high with no multiply in flight at %0t", $time);
            end
            if (start && !busy) begin // next edge accepts
                tracking = 1'b1;
                phase    = 0;
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= timeoutCycles) begin
            errors++;
            $display("timeout after %0d cycles, done never arrived", cycles);
            $display("errors: %0d, checks: %0d", errors, checks);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // stimulus
    initial begin
        logic [31:0]   rnd;
        boothOperandsT ops;
        reset     = 1'b0;
        start     = 1'b0;
        operands  = '0;
        seed      = 33827;
        errors    = 0;
        checks    = 0;
        issued    = 0;
        doneCount = 0;
        cycles    = 0;
        phase     = 0;
        tracking  = 1'b0;

        repeat (10) begin
            @(negedge clk);
            checkQuiet("during reset");
        end
        @(posedge clk);
        reset <= 1'b1;
        @(negedge clk);
        checkQuiet("right after reset");

        // corners, one at a time
        startOp(makeOps(16'sh0000, 16'sh0000));
        dropStart();
        waitDone();
        startOp(makeOps(16'sh0001, 16'shffff));
        dropStart();
        waitDone();
        startOp(makeOps(16'shffff, 16'shffff)); // all ones, one long run
        dropStart();
        waitDone();
        startOp(makeOps(16'sh7fff, 16'sh7fff));
        dropStart();
        waitDone();
        startOp(makeOps(16'sh8000, 16'sh8000)); // most negative squared
        dropStart();
        waitDone();
        startOp(makeOps(16'sh8000, 16'sh7fff));
        dropStart();
        waitDone();

        // random, back to back; start stays high into each done cycle
        for (int i = 0; i < randomOps; i++) begin
            rnd                = $random(seed);
            ops.multiplicand   = rnd[15:0];
            rnd                = $random(seed);
            ops.multiplier     = rnd[15:0];
            startOp(ops);
        end
        dropStart();
        waitDone();

        // second start mid-operation, new operands, must be ignored
        startOp(makeOps(16'sh04d2, 16'shfdc9));
        dropStart();
        repeat (5) @(posedge clk);
        start    <= 1'b1;
        operands <= makeOps(16'sh8000, 16'sh7fff);
        @(posedge clk);
        start <= 1'b0;
        waitDone();
        repeat (20) @(negedge clk); // room for a stray second done

        if (pending.size() != 0) begin
            errors++;
            $display("%0d accepted multiplies never got a done", pending.size());
        end
        if (doneCount != issued) begin
            errors++;
            $display("saw %0d done pulses for %0d accepted starts", doneCount, issued);
        end

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule : boothMultiplierTb

//--- all.f
+incdir+include
logic/boothParamPkg.sv
logic/boothTypesPkg.sv
logic/boothDatapath.sv
logic/boothController.sv
logic/boothMultiplier.sv
verif/boothMultiplierTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps --top-module boothMultiplierTb \
    -f all.f -o simv \
    && ./obj_dir/simv > sim.log 2>&1 \
    || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qF "*** TEST PASSED ***" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
